// File: all.f
sifhPkg.sv
ramIf.sv
histRam.sv
histBuilder.sv
peakFinder.sv
sifhCtrl.sv
sifhTop.sv
tbSifh.sv

// File: histBuilder.sv
`timescale 1ns/1ps

module histBuilder (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       enable,
    input  logic                       dataValid,
    input  logic [sifhPkg::binBits-1:0] data,
    output logic                       busy,
    ramIf.master                       bus
);
    import sifhPkg::*;

    logic                 take;     // event accepted this cycle

    logic                 s2Valid;  // read data arrives
    logic [binBits-1:0]   s2Bin;

    logic                 s3Valid;  // write stage
    logic [binBits-1:0]   s3Bin;
    logic [countBits-1:0] s3Count;

    logic                 s4Valid;  // value written last cycle
    logic [binBits-1:0]   s4Bin;
    logic [countBits-1:0] s4Count;

    logic [countBits-1:0] base;     // current count of the stage 2 bin
    logic [countBits-1:0] bumped;

    assign take = enable && dataValid;

    // stage 1 issues the read straight from the input
    assign bus.raddr   = data;
    assign bus.rEnable = take;

    // stage 3 writes the new count
    assign bus.waddr   = s3Bin;
    assign bus.wdata   = s3Count;
    assign bus.wEnable = s3Valid;

    // rdata misses the write happening now and the one from last cycle,
    // the newer of the two wins
    always_comb begin
        if (s3Valid && s3Bin == s2Bin) begin
            base = s3Count;
        end else if (s4Valid && s4Bin == s2Bin) begin
            base = s4Count;
        end else begin
            base = bus.rdata;
        end
    end

    assign bumped = (base == countBits'(countMax)) ? base : base + 1'b1; // saturate

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
            s4Valid <= 1'b0;
        end else begin
            s2Valid <= take;
            s3Valid <= s2Valid;
            s4Valid <= s3Valid;
        end
    end

    // payload, qualified by the valid bits
    always_ff @(posedge clk) begin
        s2Bin   <= data;
        s3Bin   <= s2Bin;
        s3Count <= bumped;
        s4Bin   <= s3Bin;
        s4Count <= s3Count;
    end

    assign busy = s2Valid || s3Valid; // stage 4 is already in the SRAM

endmodule

// File: histRam.sv
`timescale 1ns/1ps

module histRam (
    input logic clk,
    ramIf.ram   mem
);
    import sifhPkg::*;

    logic [countBits-1:0] store [binNum]; // histogram words

    // write port
    always_ff @(posedge clk) begin
        if (mem.wEnable) begin
            store[mem.waddr] <= mem.wdata;
        end
    end

    // registered read, old data on a same-address collision
    always_ff @(posedge clk) begin
        if (mem.rEnable) begin
            mem.rdata <= store[mem.raddr];
        end
    end

endmodule

// File: peakFinder.sv
`timescale 1ns/1ps

module peakFinder (
    input  logic                         clk,
    input  logic                         res,
    input  logic                         go,
    output logic                         finish,
    ramIf.master                         bus,
    output logic [sifhPkg::binBits-1:0]   peakBin,
    output logic [sifhPkg::countBits-1:0] peakCount
);
    import sifhPkg::*;

    logic                 scan;      // read address walking
    logic [binBits-1:0]   addr;
    logic                 rdValid;   // rdata holds a bin this cycle
    logic                 lastRd;    // ... and it is the last one
    logic [binBits-1:0]   rdBin;
    logic [countBits-1:0] maxCount;  // running maximum
    logic [binBits-1:0]   maxBin;
    logic                 greater;
    logic [countBits-1:0] nextCount;
    logic [binBits-1:0]   nextBin;

    // read only
    assign bus.waddr   = '0;
    assign bus.wdata   = '0;
    assign bus.wEnable = 1'b0;
    assign bus.raddr   = addr;
    assign bus.rEnable = scan;

    // strictly greater keeps the lowest index on ties
    assign greater   = bus.rdata > maxCount;
    assign nextCount = greater ? bus.rdata : maxCount;
    assign nextBin   = greater ? rdBin : maxBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scan      <= 1'b0;
            addr      <= '0;
            rdValid   <= 1'b0;
            lastRd    <= 1'b0;
            finish    <= 1'b0;
            peakBin   <= '0;
            peakCount <= '0;
        end else begin
            rdValid <= scan;
            lastRd  <= scan && (addr == binBits'(binNum - 1));
            finish  <= lastRd;
            if (go) begin
                scan <= 1'b1;
                addr <= '0;
            end else if (scan) begin
                addr <= addr + 1'b1;
                if (addr == binBits'(binNum - 1)) begin
                    scan <= 1'b0; // last bin requested
                end
            end
            if (lastRd) begin
                peakBin   <= nextBin;
                peakCount <= nextCount;
            end
        end
    end

    always_ff @(posedge clk) begin
        rdBin <= addr;
        if (go) begin
            maxCount <= '0; // empty frame reports bin 0
            maxBin   <= '0;
        end else if (rdValid) begin
            maxCount <= nextCount;
            maxBin   <= nextBin;
        end
    end

endmodule

// File: ramIf.sv
`timescale 1ns/1ps

interface ramIf;
    import sifhPkg::*;

    logic [binBits-1:0]   waddr;   // write port
    logic                 wEnable;
    logic [countBits-1:0] wdata;
    logic [binBits-1:0]   raddr;   // read port
    logic                 rEnable;
    logic [countBits-1:0] rdata;   // valid one cycle after rEnable

    modport master (
        output waddr, wEnable, wdata,
        output raddr, rEnable,
        input  rdata
    );

    modport ram (
        input  waddr, wEnable, wdata,
        input  raddr, rEnable,
        output rdata
    );

endinterface

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f all.f --top-module tbSifh -o simv
./obj_dir/simv 2>&1 | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// File: sifhCtrl.sv
`timescale 1ns/1ps

module sifhCtrl (
    input  logic clk,
    input  logic res,
    input  logic start,
    input  logic frameEnd,
    input  logic buildBusy,
    input  logic peakFinish,
    output logic ready,
    output logic buildEnable,
    output logic peakGo,
    output logic done,
    ramIf.ram    buildBus,
    ramIf.ram    peakBus,
    ramIf.master ramBus
);
    import sifhPkg::*;

    ctrlState           state;
    ctrlState           stateNext;
    logic [binBits-1:0] clrAddr;   // clear write pointer
    logic               clrWe;     // clear write strobe
    logic               clrLast;
    logic [1:0]         drainCnt;

    assign clrLast = clrWe && (clrAddr == binBits'(binNum - 1));

    always_comb begin
        stateNext = state;
        case (state)
            CLEAR: begin
                if (clrLast) begin
                    stateNext = IDLE;
                end
            end
            IDLE: begin
                if (start) begin
                    stateNext = BUILD;
                end
            end
            BUILD: begin
                if (frameEnd) begin
                    stateNext = DRAIN; // this cycle's event still counts
                end
            end
            DRAIN: begin
                if (drainCnt == 2'(drainLen - 1) && !buildBusy) begin
                    stateNext = PEAK;
                end
            end
            PEAK: begin
                if (peakFinish) begin
                    stateNext = CLEAR;
                end
            end
            default: stateNext = CLEAR;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= CLEAR;
            clrAddr  <= '0;
            clrWe    <= 1'b0;
            drainCnt <= '0;
            peakGo   <= 1'b0;
        end else begin
            state  <= stateNext;
            clrWe  <= (stateNext == CLEAR) && !clrLast;
            peakGo <= (state != PEAK) && (stateNext == PEAK); // first PEAK cycle
            if (clrWe) begin
                clrAddr <= clrAddr + 1'b1; // wraps to 0 after the last bin
            end
            if (state == DRAIN) begin
                drainCnt <= drainCnt + 1'b1;
            end else begin
                drainCnt <= '0;
            end
        end
    end

    assign ready       = (state == IDLE);
    assign buildEnable = (state == BUILD);
    assign done        = peakFinish;

    // SRAM ownership
    always_comb begin
        ramBus.waddr   = '0;
        ramBus.wEnable = 1'b0;
        ramBus.wdata   = '0;
        ramBus.raddr   = '0;
        ramBus.rEnable = 1'b0;
        case (state)
            CLEAR: begin
                ramBus.waddr   = clrAddr;
                ramBus.wEnable = clrWe;
            end
            BUILD, DRAIN: begin
                ramBus.waddr   = buildBus.waddr;
                ramBus.wEnable = buildBus.wEnable;
                ramBus.wdata   = buildBus.wdata;
                ramBus.raddr   = buildBus.raddr;
                ramBus.rEnable = buildBus.rEnable;
            end
            PEAK: begin
                ramBus.waddr   = peakBus.waddr;
                ramBus.wEnable = peakBus.wEnable;
                ramBus.wdata   = peakBus.wdata;
                ramBus.raddr   = peakBus.raddr;
                ramBus.rEnable = peakBus.rEnable;
            end
            default: ;
        endcase
    end

    assign buildBus.rdata = ramBus.rdata;
    assign peakBus.rdata  = ramBus.rdata;

endmodule

// File: sifhPatterns.txt
// columns: kind bin count, all hex
// kind 0 opens a frame, bin and count are the expected peak
// kind 1 is an event to bin, repeated count times inside the frame
// kind 2 is an event to bin, repeated count times before start, ignored
0 12 07
1 05 03
1 12 04
1 3f 02
1 12 03
0 2a 28
1 01 14
1 2a 28
0 07 3f
1 07 64
1 08 50
0 10 05
2 00 10
1 30 05
1 10 05
1 20 05
0 00 00
2 3f 08
0 00 01
1 07 01
1 00 01
0 05 04
1 05 01
1 06 01
1 05 01
1 06 01
1 05 02
1 06 01

// File: sifhPkg.sv
package sifhPkg;

    // timestamp width, doubles as SRAM address width
    localparam int binBits = 6;

    // one bin per timestamp code
    localparam int binNum = 1 << binBits;

    // width of one bin count
    localparam int countBits = 6;

    // counts stick here instead of wrapping
    localparam int countMax = (1 << countBits) - 1;

    // minimum drain length, covers the builder pipeline depth
    localparam int drainLen = 3;

    // controller phases
    typedef enum logic [2:0] {
        CLEAR = 3'd0, // zero all bins
        IDLE  = 3'd1, // wait for start
        BUILD = 3'd2, // count events
        DRAIN = 3'd3, // let builder writes land
        PEAK  = 3'd4  // scan for maximum
    } ctrlState;

endpackage

// File: sifhTop.sv
`timescale 1ns/1ps

module sifhTop (
    input  logic                         clk,
    input  logic                         res,
    input  logic                         start,
    input  logic                         frameEnd,
    input  logic                         dataValid,
    input  logic [sifhPkg::binBits-1:0]   data,
    output logic                         ready,
    output logic                         done,
    output logic [sifhPkg::binBits-1:0]   peakBin,
    output logic [sifhPkg::countBits-1:0] peakCount
);

    logic buildEnable;
    logic buildBusy;
    logic peakGo;
    logic peakFinish;

    ramIf buildBus ();
    ramIf peakBus ();
    ramIf ramBus ();

    sifhCtrl ctrl (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .frameEnd    (frameEnd),
        .buildBusy   (buildBusy),
        .peakFinish  (peakFinish),
        .ready       (ready),
        .buildEnable (buildEnable),
        .peakGo      (peakGo),
        .done        (done),
        .buildBus    (buildBus.ram),
        .peakBus     (peakBus.ram),
        .ramBus      (ramBus.master)
    );

    histBuilder builder (
        .clk       (clk),
        .res       (res),
        .enable    (buildEnable),
        .dataValid (dataValid),
        .data      (data),
        .busy      (buildBusy),
        .bus       (buildBus.master)
    );

    peakFinder finder (
        .clk       (clk),
        .res       (res),
        .go        (peakGo),
        .finish    (peakFinish),
        .bus       (peakBus.master),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    histRam ram (
        .clk (clk),
        .mem (ramBus.ram)
    );

endmodule

// File: tbSifh.sv
`timescale 1ns/1ps

module tbSifh;
    import sifhPkg::*;

    logic                 clk;
    logic                 res;
    logic                 start;
    logic                 frameEnd;
    logic                 dataValid;
    logic [binBits-1:0]   data;
    logic                 ready;
    logic                 done;
    logic [binBits-1:0]   peakBin;
    logic [countBits-1:0] peakCount;

    logic [binBits-1:0]   evQ [$];        // in-frame events of all frames back to back
    int                   frameEvFirst [$];
    int                   frameEvNum [$];
    logic [binBits-1:0]   strayQ [$];     // events given in IDLE that must not count
    int                   frameStrayFirst [$];
    int                   frameStrayNum [$];
    logic [binBits-1:0]   fileBin [$];    // peak expected by the pattern file
    logic [countBits-1:0] fileCount [$];

    int                   hist [binNum];  // reference histogram
    logic [31:0]          lfsr;
    int                   cycles = 0;
    int                   limit = 0;
    string                waitWhat = "ready";

    sifhTop uut (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .frameEnd  (frameEnd),
        .dataValid (dataValid),
        .data      (data),
        .ready     (ready),
        .done      (done),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    always #5 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    // run limit armed once the patterns are known
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            abortRun($sformatf("timeout: no %s within %0d cycles", waitWhat, limit));
        end
    end

    task automatic checkBin(input string name, input logic [binBits-1:0] got,
                            input logic [binBits-1:0] want);
        if (got !== want) begin
            abortRun($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    task automatic checkCount(input string name, input logic [countBits-1:0] got,
                              input logic [countBits-1:0] want);
        if (got !== want) begin
            abortRun($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    // Galois LFSR stepped once per bit
    function automatic logic randBit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    task automatic readPatterns();
        int          fd;
        int          code;
        int          n;
        int          idx;
        string       line;
        logic [31:0] kind;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("sifhPatterns.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open sifhPatterns.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h", kind, a, b);
            if (code > 0 && n == 3) begin // comments and blank lines fall through
                idx = frameEvNum.size() - 1;
                if (kind != 0 && idx < 0) begin
                    abortRun("pattern file has an event before the first frame record");
                end
                case (kind)
                    0: begin
                        fileBin.push_back(a[binBits-1:0]);
                        fileCount.push_back(b[countBits-1:0]);
                        frameEvFirst.push_back(evQ.size());
                        frameEvNum.push_back(0);
                        frameStrayFirst.push_back(strayQ.size());
                        frameStrayNum.push_back(0);
                    end
                    1: begin
                        repeat (b) evQ.push_back(a[binBits-1:0]);
                        frameEvNum[idx] = frameEvNum[idx] + int'(b);
                    end
                    2: begin
                        repeat (b) strayQ.push_back(a[binBits-1:0]);
                        frameStrayNum[idx] = frameStrayNum[idx] + int'(b);
                    end
                    default: abortRun("pattern file has an unknown record kind");
                endcase
            end
        end
        $fclose(fd);
    endtask

    // saturating histogram then peak with lowest index on ties
    task automatic modelFrame(input int f, output logic [binBits-1:0] expBin,
                              output logic [countBits-1:0] expCount);
        int best;
        int bestBin;
        int b;
        for (int i = 0; i < binNum; i++) begin
            hist[i] = 0;
        end
        for (int j = 0; j < frameEvNum[f]; j++) begin
            b = int'(evQ[frameEvFirst[f] + j]);
            if (hist[b] < countMax) begin
                hist[b] = hist[b] + 1;
            end
        end
        best = 0;
        bestBin = 0;
        for (int i = 0; i < binNum; i++) begin
            if (hist[i] > best) begin
                best = hist[i];
                bestBin = i;
            end
        end
        expBin = binBits'(bestBin);
        expCount = countBits'(best);
    endtask

    task automatic runFrame(input int f);
        logic [binBits-1:0]   expBin;
        logic [countBits-1:0] expCount;
        logic                 gap;
        int                   last;
        modelFrame(f, expBin, expCount);
        if (expBin !== fileBin[f] || expCount !== fileCount[f]) begin
            abortRun($sformatf("pattern file frame %0d disagrees with the model peak", f));
        end

        waitWhat = "ready";
        while (ready !== 1'b1) @(negedge clk);

        // noise while idle before any start
        for (int j = 0; j < frameStrayNum[f]; j++) begin
            dataValid = 1'b1;
            data = strayQ[frameStrayFirst[f] + j];
            @(negedge clk);
        end
        dataValid = 1'b0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;

        last = frameEvNum[f] - 1;
        if (frameEvNum[f] == 0) begin
            frameEnd = 1'b1; // empty frame
            @(negedge clk);
        end
        for (int j = 0; j <= last; j++) begin
            gap = randBit();
            if (gap) begin
                dataValid = 1'b0;
                @(negedge clk);
            end
            dataValid = 1'b1;
            data = evQ[frameEvFirst[f] + j];
            frameEnd = (j == last); // last event rides with frameEnd
            @(negedge clk);
        end
        dataValid = 1'b0;
        frameEnd = 1'b0;

        waitWhat = "done";
        while (done !== 1'b1) @(negedge clk);
        checkBin("peakBin", peakBin, expBin);
        checkCount("peakCount", peakCount, expCount);
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        res = 1'b0;
        start = 1'b0;
        frameEnd = 1'b0;
        dataValid = 1'b0;
        data = '0;
        lfsr = 32'h40af7e14;

        readPatterns();
        limit = (evQ.size() + strayQ.size()) * 2 + fileBin.size() * 200 + 200;

        repeat (4) @(negedge clk);
        res = 1'b1;

        for (int f = 0; f < fileBin.size(); f++) begin
            runFrame(f);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule
